// File: hdl/dodge_pkg.sv
package dodge_pkg;

	// ========================================================================
	// Game geometry and timing
	// ========================================================================
	localparam int row_width = 8;
	localparam int image_width = row_width * row_width;
	localparam int score_width = 8;

	localparam logic [row_width-1:0] p1_start_pos = 8'b0010_0000;
	localparam logic [row_width-1:0] p2_start_pos = 8'b0000_0100;

	// Shortened step periods for simulation
	localparam int step_cycles_l1 = 1024;
	localparam int step_cycles_l2 = 768;
	localparam int step_cycles_l3 = 512;
	localparam int step_width = $clog2(step_cycles_l1);

	localparam int level_points = 8;
	localparam int win_score = 24;

	localparam int go_cycles = 256;
	localparam int go_width = $clog2(go_cycles);

	// Obstacle generator polynomial x^8 + x^6 + x^5 + x^4 + 1
	localparam logic [row_width-1:0] lfsr_seed = 8'hA5;
	localparam logic [row_width-1:0] lfsr_taps = 8'hB8;

	// General FSM states
	localparam logic [1:0] st_wait = 2'd0;
	localparam logic [1:0] st_go = 2'd1;
	localparam logic [1:0] st_play = 2'd2;
	localparam logic [1:0] st_result = 2'd3;

	// ========================================================================
	// Fixed screens with row 7 in the top byte
	// ========================================================================
	localparam logic [2:0] screen_wait = 3'd0;
	localparam logic [2:0] screen_go = 3'd1;
	localparam logic [2:0] screen_win = 3'd2;
	localparam logic [2:0] screen_p1_alive = 3'd3;
	localparam logic [2:0] screen_p2_alive = 3'd4;

	localparam logic [image_width-1:0] pat_go = {
		8'b00000000, 8'b01100110, 8'b10001001, 8'b10001001,
		8'b10111001, 8'b10011001, 8'b01100110, 8'b00000000};
	localparam logic [image_width-1:0] pat_win = {
		8'b00000000, 8'b00100100, 8'b00100100, 8'b00000000,
		8'b01000010, 8'b00100100, 8'b00111100, 8'b00000000};
	localparam logic [image_width-1:0] pat_p1_alive = {
		8'b00001111, 8'b01101111, 8'b00001111, 8'b10011111,
		8'b01101111, 8'b00001111, 8'b00001111, 8'b00001111};
	localparam logic [image_width-1:0] pat_p2_alive = {
		8'b11110000, 8'b11110110, 8'b11110000, 8'b11111001,
		8'b11110110, 8'b11110000, 8'b11110000, 8'b11110000};

	// ========================================================================
	// MAX7219 registers and serial frame
	// ========================================================================
	localparam logic [3:0] reg_digit0 = 4'h1;
	localparam logic [3:0] reg_decode = 4'h9;
	localparam logic [3:0] reg_intensity = 4'hA;
	localparam logic [3:0] reg_scan_limit = 4'hB;
	localparam logic [3:0] reg_shutdown = 4'hC;
	localparam logic [3:0] reg_display_test = 4'hF;

	localparam logic [3:0] intensity_level = 4'hA;
	localparam int max_init_frames = 5;
	// Minimum ncs high time between frames
	localparam int frame_gap = 4;
	localparam int gap_width = $clog2(frame_gap);

	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [3:0] reserved;
			logic [3:0] addr;
			logic [7:0] data;
		} fields;
	} max_frame_u;

endpackage

// File: hdl/player_ctrl.sv
`timescale 1ns/1ns

module player_ctrl #(
	parameter logic [dodge_pkg::row_width-1:0] start_pos = dodge_pkg::p1_start_pos
) (
	input  logic clock_50,
	input  logic reset,
	input  logic playing,
	input  logic restart,
	input  logic move_left,
	input  logic move_right,
	output logic [dodge_pkg::row_width-1:0] pos
);

	logic left_q;
	logic right_q;
	logic left_rise;
	logic right_rise;
	logic at_left_edge;
	logic at_right_edge;

	// Buttons are clean levels, only the press edge counts
	assign left_rise = move_left & ~left_q;
	assign right_rise = move_right & ~right_q;

	assign at_left_edge = pos[dodge_pkg::row_width-1];
	assign at_right_edge = pos[0];

	always_ff @(posedge clock_50) begin
		if (reset) begin
			left_q <= 1'b0;
			right_q <= 1'b0;
			pos <= start_pos;
		end else begin
			left_q <= move_left;
			right_q <= move_right;
			if (restart) begin
				pos <= start_pos;
			end else if (playing) begin
				// Simultaneous presses cancel out
				if (left_rise && !right_rise && !at_left_edge) begin
					pos <= pos << 1;
				end else if (right_rise && !left_rise && !at_right_edge) begin
					pos <= pos >> 1;
				end
			end
		end
	end

endmodule

// File: hdl/obstacle_field.sv
`timescale 1ns/1ns

module obstacle_field (
	input  logic clock_50,
	input  logic reset,
	input  logic step,
	input  logic screen_load,
	input  logic [2:0] screen_sel,
	input  logic playing,
	input  logic [dodge_pkg::row_width-1:0] pos_p1,
	input  logic [dodge_pkg::row_width-1:0] pos_p2,
	output logic hit_p1,
	output logic hit_p2,
	output logic [dodge_pkg::image_width-1:0] image,
	output logic [dodge_pkg::row_width-1:0] test_row
);

	// rows[0] is the bottom row where the players live
	logic [dodge_pkg::row_width-1:0][dodge_pkg::row_width-1:0] rows;
	logic [dodge_pkg::row_width-1:0] lfsr;
	logic lfsr_fb;
	logic [dodge_pkg::image_width-1:0] pattern;
	logic [dodge_pkg::row_width-1:0] row0_view;

	// ========================================================================
	// Screen selection
	// ========================================================================
	always_comb begin
		case (screen_sel)
			dodge_pkg::screen_wait: pattern = '0;
			dodge_pkg::screen_go: pattern = dodge_pkg::pat_go;
			dodge_pkg::screen_win: pattern = dodge_pkg::pat_win;
			dodge_pkg::screen_p1_alive: pattern = dodge_pkg::pat_p1_alive;
			dodge_pkg::screen_p2_alive: pattern = dodge_pkg::pat_p2_alive;
			default: pattern = '0;
		endcase
	end

	// ========================================================================
	// Row registers and obstacle generator
	// ========================================================================
	assign lfsr_fb = ^(lfsr & dodge_pkg::lfsr_taps);

	always_ff @(posedge clock_50) begin
		if (reset) begin
			rows <= '0;
			lfsr <= dodge_pkg::lfsr_seed;
		end else if (screen_load) begin
			rows <= pattern;
		end else if (step) begin
			// Everything falls one row, new obstacle enters at the top
			rows <= {lfsr, rows[dodge_pkg::row_width-1:1]};
			lfsr <= {lfsr[dodge_pkg::row_width-2:0], lfsr_fb};
		end
	end

	// Collisions look at the field only, not at the markers
	assign hit_p1 = |(rows[0] & pos_p1);
	assign hit_p2 = |(rows[0] & pos_p2);

	// Player markers are drawn over the bottom row during play
	always_comb begin
		row0_view = rows[0];
		if (playing) begin
			row0_view = rows[0] | pos_p1 | pos_p2;
		end
	end

	assign image = {rows[dodge_pkg::row_width-1:1], row0_view};
	assign test_row = row0_view;

endmodule

// File: hdl/game_ctrl.sv
`timescale 1ns/1ns

module game_ctrl (
	input  logic clock_50,
	input  logic reset,
	input  logic start_button,
	input  logic hit_p1,
	input  logic hit_p2,
	output logic playing,
	output logic restart,
	output logic step,
	output logic screen_load,
	output logic [2:0] screen_sel,
	output logic [dodge_pkg::score_width-1:0] score
);

	logic [1:0] state;
	logic start_q;
	logic start_rise;
	// High the cycle after a step when the scrolled row 0 is valid
	logic check;
	logic [dodge_pkg::go_width-1:0] go_cnt;
	logic [dodge_pkg::step_width-1:0] step_cnt;
	logic [dodge_pkg::step_width-1:0] step_limit;
	logic [dodge_pkg::score_width-1:0] next_score;

	assign start_rise = start_button & ~start_q;
	assign next_score = score + 1'b1;

	// Speed level follows the score up to level 3
	always_comb begin
		if (score < dodge_pkg::level_points) begin
			step_limit = dodge_pkg::step_width'(dodge_pkg::step_cycles_l1 - 1);
		end else if (score < 2 * dodge_pkg::level_points) begin
			step_limit = dodge_pkg::step_width'(dodge_pkg::step_cycles_l2 - 1);
		end else begin
			step_limit = dodge_pkg::step_width'(dodge_pkg::step_cycles_l3 - 1);
		end
	end

	// ========================================================================
	// General FSM with go timer, speed counter and point counter
	// ========================================================================
	always_ff @(posedge clock_50) begin
		if (reset) begin
			state <= dodge_pkg::st_wait;
			start_q <= 1'b0;
			check <= 1'b0;
			go_cnt <= '0;
			step_cnt <= '0;
			playing <= 1'b0;
			restart <= 1'b0;
			step <= 1'b0;
			screen_load <= 1'b0;
			screen_sel <= dodge_pkg::screen_wait;
			score <= '0;
		end else begin
			start_q <= start_button;
			check <= step;
			restart <= 1'b0;
			step <= 1'b0;
			screen_load <= 1'b0;
			if (restart) begin
				score <= '0;
			end
			case (state)
				dodge_pkg::st_wait, dodge_pkg::st_result: begin
					if (start_rise) begin
						state <= dodge_pkg::st_go;
						restart <= 1'b1;
						screen_load <= 1'b1;
						screen_sel <= dodge_pkg::screen_go;
						go_cnt <= '0;
					end
				end
				dodge_pkg::st_go: begin
					if (go_cnt == dodge_pkg::go_width'(dodge_pkg::go_cycles - 1)) begin
						state <= dodge_pkg::st_play;
						playing <= 1'b1;
						step_cnt <= '0;
					end else begin
						go_cnt <= go_cnt + 1'b1;
					end
				end
				dodge_pkg::st_play: begin
					if (step_cnt == step_limit) begin
						step <= 1'b1;
						step_cnt <= '0;
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
					if (check) begin
						if (hit_p1 || hit_p2) begin
							state <= dodge_pkg::st_result;
							playing <= 1'b0;
							screen_load <= 1'b1;
							if (hit_p1 && hit_p2) begin
								screen_sel <= dodge_pkg::screen_wait;
							end else if (hit_p1) begin
								screen_sel <= dodge_pkg::screen_p2_alive;
							end else begin
								screen_sel <= dodge_pkg::screen_p1_alive;
							end
						end else begin
							score <= next_score;
							// Both survived long enough
							if (next_score == dodge_pkg::score_width'(dodge_pkg::win_score)) begin
								state <= dodge_pkg::st_result;
								playing <= 1'b0;
								screen_load <= 1'b1;
								screen_sel <= dodge_pkg::screen_win;
							end
						end
					end
				end
				default: state <= dodge_pkg::st_wait;
			endcase
		end
	end

endmodule

// File: hdl/max7219_driver.sv
`timescale 1ns/1ns

module max7219_driver (
	input  logic clock_50,
	input  logic reset,
	input  logic [dodge_pkg::image_width-1:0] image,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	// Frames 0..4 are init frames and the rest are digits 1..8
	logic [3:0] frame_idx;
	logic [3:0] digit;
	logic [2:0] col;
	logic [dodge_pkg::row_width-1:0] col_data;
	dodge_pkg::max_frame_u frame;
	logic [15:0] shift_reg;
	logic [3:0] bit_cnt;
	logic busy;
	logic [dodge_pkg::gap_width-1:0] gap_cnt;

	// ========================================================================
	// Frame contents
	// ========================================================================
	always_comb begin
		digit = frame_idx - 4'(dodge_pkg::max_init_frames);
		col = 3'd7 - digit[2:0];
		// Row 0 goes out in bit 7
		for (int r = 0; r < dodge_pkg::row_width; r++) begin
			col_data[dodge_pkg::row_width-1-r] = image[r*dodge_pkg::row_width + col];
		end
	end

	always_comb begin
		frame.raw = '0;
		case (frame_idx)
			4'd0: begin
				frame.fields.addr = dodge_pkg::reg_shutdown;
				frame.fields.data = 8'h01;
			end
			4'd1: begin
				frame.fields.addr = dodge_pkg::reg_scan_limit;
				frame.fields.data = 8'h07;
			end
			4'd2: frame.fields.addr = dodge_pkg::reg_decode;
			4'd3: begin
				frame.fields.addr = dodge_pkg::reg_intensity;
				frame.fields.data = {4'h0, dodge_pkg::intensity_level};
			end
			4'd4: frame.fields.addr = dodge_pkg::reg_display_test;
			default: begin
				frame.fields.addr = dodge_pkg::reg_digit0 + digit;
				frame.fields.data = col_data;
			end
		endcase
	end

	// ========================================================================
	// Serial shifter sending MSB first at half the system clock rate
	// ========================================================================
	always_ff @(posedge clock_50) begin
		if (reset) begin
			frame_idx <= '0;
			busy <= 1'b0;
			gap_cnt <= '0;
			bit_cnt <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
			max7219_din <= 1'b0;
		end else if (!busy) begin
			if (gap_cnt == dodge_pkg::gap_width'(dodge_pkg::frame_gap - 1)) begin
				// Image is sampled here once per frame
				busy <= 1'b1;
				max7219_ncs <= 1'b0;
				max7219_din <= frame.raw[15];
				shift_reg <= {frame.raw[14:0], 1'b0};
				bit_cnt <= '0;
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end else if (!max7219_clk) begin
			max7219_clk <= 1'b1;
		end else begin
			max7219_clk <= 1'b0;
			if (bit_cnt == 4'd15) begin
				busy <= 1'b0;
				gap_cnt <= '0;
				max7219_ncs <= 1'b1;
				max7219_din <= 1'b0;
				if (frame_idx == 4'(dodge_pkg::max_init_frames + dodge_pkg::row_width - 1)) begin
					frame_idx <= 4'(dodge_pkg::max_init_frames);
				end else begin
					frame_idx <= frame_idx + 1'b1;
				end
			end else begin
				max7219_din <= shift_reg[15];
				shift_reg <= {shift_reg[14:0], 1'b0};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

// File: hdl/dodge_top.sv
`timescale 1ns/1ns

module dodge_top (
	input  logic clock_50,
	input  logic reset,
	input  logic start_button,
	input  logic left_p1,
	input  logic right_p1,
	input  logic left_p2,
	input  logic right_p2,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk,
	output logic [dodge_pkg::row_width-1:0] test_row,
	output logic [dodge_pkg::score_width-1:0] score
);

	logic playing;
	logic restart;
	logic step;
	logic screen_load;
	logic [2:0] screen_sel;
	logic [dodge_pkg::row_width-1:0] pos_p1;
	logic [dodge_pkg::row_width-1:0] pos_p2;
	logic hit_p1;
	logic hit_p2;
	logic [dodge_pkg::image_width-1:0] image;

	// ========================================================================
	// Players
	// ========================================================================
	player_ctrl #(.start_pos(dodge_pkg::p1_start_pos)) p1 (
		.clock_50(clock_50), .reset(reset), .playing(playing), .restart(restart),
		.move_left(left_p1), .move_right(right_p1), .pos(pos_p1)
	);

	player_ctrl #(.start_pos(dodge_pkg::p2_start_pos)) p2 (
		.clock_50(clock_50), .reset(reset), .playing(playing), .restart(restart),
		.move_left(left_p2), .move_right(right_p2), .pos(pos_p2)
	);

	// Matrix field, general controller and display
	obstacle_field obstacle_field_inst (
		.clock_50(clock_50), .reset(reset), .step(step), .screen_load(screen_load),
		.screen_sel(screen_sel), .playing(playing), .pos_p1(pos_p1), .pos_p2(pos_p2),
		.hit_p1(hit_p1), .hit_p2(hit_p2), .image(image), .test_row(test_row)
	);

	game_ctrl game_ctrl_inst (
		.clock_50(clock_50), .reset(reset), .start_button(start_button),
		.hit_p1(hit_p1), .hit_p2(hit_p2), .playing(playing), .restart(restart),
		.step(step), .screen_load(screen_load), .screen_sel(screen_sel), .score(score)
	);

	max7219_driver max7219_driver_inst (
		.clock_50(clock_50), .reset(reset), .image(image), .max7219_din(max7219_din),
		.max7219_ncs(max7219_ncs), .max7219_clk(max7219_clk)
	);

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int period = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

// File: sim/dodge_chk.sv
`timescale 1ns/1ns

module dodge_chk (
	input logic clock_50,
	input logic reset,
	input logic max7219_ncs,
	input logic max7219_clk,
	input logic restart,
	input logic [dodge_pkg::score_width-1:0] score
);

	// Serial clock idles low between frames
	clk_idle: assert property (@(posedge clock_50) disable iff (reset)
		max7219_ncs |-> !max7219_clk)
		else $error("max7219_clk high while ncs is high");

	// Chip select stays inactive right after reset
	ncs_after_reset: assert property (@(posedge clock_50)
		$fell(reset) |-> max7219_ncs ##1 max7219_ncs)
		else $error("ncs dropped too early after reset");

	score_monotonic: assert property (@(posedge clock_50) disable iff (reset)
		(score >= $past(score)) || $past(restart))
		else $error("score decreased without a restart");

endmodule

bind dodge_top dodge_chk dodge_chk_inst (
	.clock_50(clock_50), .reset(reset), .max7219_ncs(max7219_ncs),
	.max7219_clk(max7219_clk), .restart(restart), .score(score)
);

// File: sim/dodge_tb.sv
`timescale 1ns/1ns

module dodge_tb;

	localparam int scan_timeout = 600;
	localparam int frame_timeout = 200;
	localparam int step_timeout = dodge_pkg::step_cycles_l1 + 200;

	logic clock_50;
	logic reset;
	logic start_button;
	logic left_p1;
	logic right_p1;
	logic left_p2;
	logic right_p2;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	logic [dodge_pkg::row_width-1:0] test_row;
	logic [dodge_pkg::score_width-1:0] score;

	// Serial decoder state
	logic [15:0] rx_shift;
	int rx_bits;
	logic clk_q = 1'b0;
	logic ncs_q = 1'b1;
	logic [7:0] digit_reg [1:8];
	logic [15:0] init_log [0:4];
	int frame_count;
	int scan_count;
	int cycle_count = 0;

	// Reference model
	logic [7:0] rows_m [0:7];
	logic [7:0] lfsr_m;
	logic [7:0] p1_m;
	logic [7:0] p2_m;
	int score_m;
	logic [63:0] end_screen;
	int interval [0:2];
	int last_change;

	int errors;
	int test_errors;
	int tests;
	logic hung;

	tb_clock #(.period(4)) clock_gen (.clk(clock_50));

	dodge_top dodge_top_inst (
		.clock_50(clock_50), .reset(reset), .start_button(start_button),
		.left_p1(left_p1), .right_p1(right_p1), .left_p2(left_p2), .right_p2(right_p2),
		.max7219_din(max7219_din), .max7219_ncs(max7219_ncs), .max7219_clk(max7219_clk),
		.test_row(test_row), .score(score)
	);

	always @(posedge clock_50) cycle_count <= cycle_count + 1;

	// ========================================================================
	// MAX7219 decoder sampling the serial lines before each clock edge
	// ========================================================================
	always @(posedge clock_50) begin
		dodge_pkg::max_frame_u rx;
		if (reset) begin
			rx_bits = 0;
			frame_count = 0;
			scan_count = 0;
		end else begin
			if (max7219_clk && !clk_q && !max7219_ncs) begin
				rx_shift = {rx_shift[14:0], max7219_din};
				rx_bits++;
			end
			if (max7219_ncs && !ncs_q) begin
				rx.raw = rx_shift;
				if (rx_bits != 16) begin
					$display("Frame %0d carried %0d bits instead of 16", frame_count, rx_bits);
					errors++;
				end
				if (frame_count < 5) begin
					init_log[frame_count] = rx.raw;
				end
				if (rx.fields.addr >= 4'd1 && rx.fields.addr <= 4'd8) begin
					digit_reg[rx.fields.addr] = rx.fields.data;
				end
				if (rx.fields.addr == 4'd8) begin
					scan_count++;
				end
				frame_count++;
				rx_bits = 0;
			end
		end
		clk_q = max7219_clk;
		ncs_q = max7219_ncs;
	end

	// Digit d holds column 8-d with row 0 in bit 7
	function automatic logic [63:0] decoded_image();
		logic [63:0] img;
		for (int c = 0; c < 8; c++) begin
			for (int r = 0; r < 8; r++) begin
				img[r * 8 + c] = digit_reg[8 - c][7 - r];
			end
		end
		return img;
	endfunction

	function automatic logic [15:0] frame_word(input logic [3:0] addr, input logic [7:0] data);
		dodge_pkg::max_frame_u f;
		f.raw = '0;
		f.fields.addr = addr;
		f.fields.data = data;
		return f.raw;
	endfunction

	// ========================================================================
	// Reference model
	// ========================================================================
	function automatic logic [7:0] lfsr_next(input logic [7:0] v);
		return {v[6:0], ^(v & dodge_pkg::lfsr_taps)};
	endfunction

	function automatic logic [7:0] shifted(input logic [7:0] pos, input bit left);
		if (left) begin
			return pos[7] ? pos : pos << 1;
		end
		return pos[0] ? pos : pos >> 1;
	endfunction

	function automatic logic [7:0] row0_view();
		return rows_m[0] | p1_m | p2_m;
	endfunction

	function automatic logic [63:0] model_image();
		logic [63:0] img;
		for (int r = 0; r < 8; r++) begin
			img[r * 8 +: 8] = (r == 0) ? row0_view() : rows_m[r];
		end
		return img;
	endfunction

	function automatic int level_of(input int s);
		return (s / dodge_pkg::level_points > 2) ? 2 : s / dodge_pkg::level_points;
	endfunction

	task automatic load_rows(input logic [63:0] pattern);
		for (int r = 0; r < 8; r++) begin
			rows_m[r] = pattern[r * 8 +: 8];
		end
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %s", name, (errors == test_errors) ? "ok" : "failed");
		tests++;
		test_errors = errors;
	endtask

	// ========================================================================
	// Bounded waits
	// ========================================================================
	task automatic wait_frames(input int n);
		int count;
		count = 0;
		while (!hung && frame_count < n) begin
			@(negedge clock_50);
			count++;
			if (count > n * frame_timeout) begin
				$display("Timed out waiting for %0d MAX7219 frames", n);
				hung = 1'b1;
			end
		end
	endtask

	task automatic wait_scans(input int n);
		int target;
		int count;
		target = scan_count + n;
		count = 0;
		while (!hung && scan_count < target) begin
			@(negedge clock_50);
			count++;
			if (count > n * scan_timeout) begin
				$display("Timed out waiting for %0d display scans", n);
				hung = 1'b1;
			end
		end
	endtask

	task automatic wait_row(input logic [7:0] expected);
		int count;
		count = 0;
		while (!hung && test_row !== expected) begin
			@(negedge clock_50);
			count++;
			if (count > step_timeout) begin
				$display("Timed out waiting for test_row to become %h", expected);
				hung = 1'b1;
			end
		end
	endtask

	task automatic wait_row_change(input logic [7:0] old_row);
		int count;
		count = 0;
		while (!hung && test_row === old_row) begin
			@(negedge clock_50);
			count++;
			if (count > step_timeout) begin
				$display("Timed out waiting for test_row to leave %h", old_row);
				hung = 1'b1;
			end
		end
	endtask

	task automatic wait_score(input logic [7:0] old_score);
		int count;
		count = 0;
		while (!hung && score === old_score) begin
			@(negedge clock_50);
			count++;
			if (count > step_timeout) begin
				$display("Timed out waiting for the score to change from %0d", old_score);
				hung = 1'b1;
			end
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================
	task automatic press_start();
		@(negedge clock_50);
		start_button = 1'b1;
		@(negedge clock_50);
		start_button = 1'b0;
		@(negedge clock_50);
	endtask

	task automatic press_move(input int player, input bit left);
		@(negedge clock_50);
		left_p1 = (player == 1) && left;
		right_p1 = (player == 1) && !left;
		left_p2 = (player == 2) && left;
		right_p2 = (player == 2) && !left;
		@(negedge clock_50);
		left_p1 = 1'b0;
		right_p1 = 1'b0;
		left_p2 = 1'b0;
		right_p2 = 1'b0;
		@(negedge clock_50);
		if (player == 1) begin
			p1_m = shifted(p1_m, left);
		end else begin
			p2_m = shifted(p2_m, left);
		end
	endtask

	task automatic random_move();
		int player;
		bit left;
		player = $urandom_range(2, 1);
		left = $urandom_range(1, 0) == 1;
		press_move(player, left);
	endtask

	// Walks a player to a random free column of the next bottom row
	task automatic steer(input int player);
		logic [7:0] next_row;
		logic [7:0] target;
		int start;
		next_row = rows_m[1];
		target = (player == 1) ? p1_m : p2_m;
		if ((next_row & target) != 8'd0 && next_row != 8'hFF) begin
			start = $urandom_range(7, 0);
			target = 8'd0;
			for (int i = 0; i < 8; i++) begin
				if (target == 8'd0 && !next_row[(start + i) % 8]) begin
					target = 8'd1 << ((start + i) % 8);
				end
			end
			while (((player == 1) ? p1_m : p2_m) != target) begin
				press_move(player, target > ((player == 1) ? p1_m : p2_m));
			end
		end
	endtask

	task automatic start_game();
		press_start();
		load_rows(dodge_pkg::pat_go);
		score_m = 0;
		p1_m = dodge_pkg::p1_start_pos;
		p2_m = dodge_pkg::p2_start_pos;
		// The GO screen shows its own bottom row until play begins
		wait_row_change(dodge_pkg::pat_go[7:0]);
		compare("play_row", 64'(row0_view()), 64'(test_row));
		compare("score_cleared", 64'd0, 64'(score));
		last_change = cycle_count;
		wait_scans(2);
		compare("go_image", model_image(), decoded_image());
	endtask

	task automatic run_game(input bit careful);
		logic [7:0] old_score;
		logic hit1;
		logic hit2;
		bit done;
		done = 1'b0;
		while (!done && !hung) begin
			if (careful) begin
				steer(1);
				steer(2);
			end else begin
				random_move();
			end
			compare("row_before_step", 64'(row0_view()), 64'(test_row));
			for (int r = 0; r < 7; r++) begin
				rows_m[r] = rows_m[r + 1];
			end
			rows_m[7] = lfsr_m;
			lfsr_m = lfsr_next(lfsr_m);
			hit1 = |(rows_m[0] & p1_m);
			hit2 = |(rows_m[0] & p2_m);
			old_score = score;
			if (!hit1 && !hit2) begin
				wait_score(old_score);
				score_m++;
				compare("score", 64'(score_m), 64'(score));
				if (score_m > 1) begin
					interval[level_of(score_m - 1)] = cycle_count - last_change;
				end
				last_change = cycle_count;
				if (score_m == dodge_pkg::win_score) begin
					end_screen = dodge_pkg::pat_win;
					done = 1'b1;
				end else begin
					compare("row_after_step", 64'(row0_view()), 64'(test_row));
				end
			end else begin
				if (hit1 && hit2) begin
					end_screen = '0;
				end else if (hit1) begin
					end_screen = dodge_pkg::pat_p2_alive;
				end else begin
					end_screen = dodge_pkg::pat_p1_alive;
				end
				wait_row(end_screen[7:0]);
				done = 1'b1;
			end
		end
	endtask

	task automatic check_end();
		logic [7:0] held;
		held = score;
		// Longer than any step period so the last step has landed
		repeat (dodge_pkg::step_cycles_l1 + 100) @(negedge clock_50);
		compare("final_score", 64'(score_m), 64'(score));
		compare("score_frozen", 64'(held), 64'(score));
		wait_scans(2);
		compare("end_image", end_screen, decoded_image());
		compare("end_row", 64'(end_screen[7:0]), 64'(test_row));
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		logic [15:0] init_expected [0:4];
		void'($urandom(32'h6f483ea1));
		reset = 1'b1;
		start_button = 1'b0;
		left_p1 = 1'b0;
		right_p1 = 1'b0;
		left_p2 = 1'b0;
		right_p2 = 1'b0;
		errors = 0;
		test_errors = 0;
		tests = 0;
		hung = 1'b0;
		lfsr_m = dodge_pkg::lfsr_seed;
		last_change = 0;
		for (int i = 0; i < 3; i++) begin
			interval[i] = 0;
		end
		for (int d = 1; d <= 8; d++) begin
			digit_reg[d] = 'x;
		end
		init_expected[0] = frame_word(dodge_pkg::reg_shutdown, 8'h01);
		init_expected[1] = frame_word(dodge_pkg::reg_scan_limit, 8'h07);
		init_expected[2] = frame_word(dodge_pkg::reg_decode, 8'h00);
		init_expected[3] = frame_word(dodge_pkg::reg_intensity, {4'h0, dodge_pkg::intensity_level});
		init_expected[4] = frame_word(dodge_pkg::reg_display_test, 8'h00);
		repeat (2) @(posedge clock_50);
		@(negedge clock_50);
		reset = 1'b0;

		wait_frames(5);
		for (int i = 0; i < 5; i++) begin
			compare("init_frame", 64'(init_expected[i]), 64'(init_log[i]));
		end
		wait_scans(1);
		compare("idle_image", 64'd0, decoded_image());
		finish_test("init");

		start_game();
		finish_test("start");

		// Plenty of time before the first step
		for (int i = 0; i < 20; i++) begin
			random_move();
			compare("move_row", 64'(row0_view()), 64'(test_row));
		end
		finish_test("movement");

		run_game(1'b1);
		if (interval[1] == 0 || interval[1] >= interval[0]) begin
			$display("ERROR speed_l2 expected below %0d actual %0d", interval[0], interval[1]);
			errors++;
		end
		if (interval[2] == 0 || interval[2] >= interval[1]) begin
			$display("ERROR speed_l3 expected below %0d actual %0d", interval[1], interval[2]);
			errors++;
		end
		finish_test("scrolling");

		check_end();
		finish_test("end_of_game");

		start_game();
		finish_test("restart");

		run_game(1'b0);
		check_end();
		finish_test("second_game");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0 && !hung) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
hdl/dodge_pkg.sv
hdl/player_ctrl.sv
hdl/obstacle_field.sv
hdl/game_ctrl.sv
hdl/max7219_driver.sv
hdl/dodge_top.sv
sim/tb_clock.sv
sim/dodge_chk.sv
sim/dodge_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dodge_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
